// File: project.f
hdl/packet_playback_pkg.sv
hdl/packet_playback_regs.sv
hdl/packet_mem.sv
hdl/packet_playback_ctrl.sv
hdl/axi4s_from_packet_adapter.sv
hdl/axi4s_packet_playback.sv
sim/axi4s_packet_playback_chk.sv
sim/axi4s_packet_playback_tb.sv

// File: Makefile
# Verilator build and run of the packet playback testbench
TOP := axi4s_packet_playback_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	verilator --binary --timing -j 0 -Wno-fatal --assert --top-module $(TOP) \
		-f project.f -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) && echo "Result: pass" || \
		(echo "Result: fail"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: sim/axi4s_packet_playback_tb.sv
// Testbench for the AXI-Stream packet playback block
// Test table, LFSR payload and tready, stream monitor, timeout
module axi4s_packet_playback_tb;

    localparam int NUM_TESTS = 8;
    localparam int MEM_WORDS = 64;

    // One row per packet
    typedef struct packed {
        logic [15:0] len;
        logic [7:0]  tid;
        logic [7:0]  tdest;
        logic [15:0] tuser;
        logic        enable;
        logic        rand_rdy;
    } test_t;

    logic        clk;
    logic        rst_n;
    logic        wr_en;
    logic [2:0]  wr_addr;
    logic [31:0] wr_data;
    logic        rd_en;
    logic [2:0]  rd_addr;
    logic [31:0] rd_data;
    logic        en;
    logic        tvalid;
    logic        tready;
    logic [63:0] tdata;
    logic [7:0]  tkeep;
    logic        tlast;
    logic [7:0]  tid;
    logic [7:0]  tdest;
    logic [15:0] tuser;

    test_t       tests [NUM_TESTS];
    // Copy of the payload memory
    logic [63:0] model [MEM_WORDS];
    logic [31:0] lfsr_state;
    // Expected packet, set before each start
    int          exp_words;
    logic [7:0]  exp_keep;
    logic [7:0]  exp_tid;
    logic [7:0]  exp_tdest;
    logic [15:0] exp_tuser;
    int          pkts_started;
    // Monitor progress
    int          pkts_seen;
    int          word_idx;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;

    axi4s_packet_playback uut (
        .clk, .rst_n, .wr_en, .wr_addr, .wr_data, .rd_en, .rd_addr, .rd_data, .en,
        .tvalid, .tready, .tdata, .tkeep, .tlast, .tid, .tdest, .tuser
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Galois LFSR, one step per bit
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) lfsr_state = lfsr_state ^ 32'h8020_0003;
        return out;
    endfunction

    function automatic logic [63:0] random_word();
        logic [63:0] w;
        for (int b = 0; b < 64; b++) w[b] = lfsr_bit();
        return w;
    endfunction

    // Zero length plays as one byte
    function automatic int byte_count(input logic [15:0] len);
        return (len == 16'd0) ? 1 : int'(len);
    endfunction

    function automatic int word_count(input logic [15:0] len);
        return (byte_count(len) + 7) / 8;
    endfunction

    // Low bytes of the final word, full word when it fills evenly
    function automatic logic [7:0] keep_mask(input logic [15:0] len);
        int rem;
        rem = byte_count(len) % 8;
        return (rem == 0) ? 8'hff : 8'((1 << rem) - 1);
    endfunction

    task automatic fail_run(input string why);
        $display("ERROR at %0t: %s", $time, why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH at %0t: %s expected %0h actual %0h",
                     $time, name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    // Called on a falling edge, returns on the next one
    task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = data;
        @(negedge clk);
        wr_en   = 1'b0;
    endtask

    task automatic read_reg(input logic [2:0] addr, output logic [31:0] data);
        rd_en   = 1'b1;
        rd_addr = addr;
        @(negedge clk);
        rd_en   = 1'b0;
        data    = rd_data;
    endtask

    // Stream monitor
    always @(posedge clk) begin
        if (!rst_n) begin
            word_idx  <= 0;
            pkts_seen <= 0;
        end else if (tvalid) begin
            if (pkts_seen >= pkts_started) begin
                fail_run("tvalid high with no packet pending");
            end else if (tready) begin
                check_value("tdata", model[word_idx], tdata);
                check_value("tkeep", (word_idx == exp_words - 1) ? exp_keep : 8'hff, tkeep);
                check_value("tlast", 64'(word_idx == exp_words - 1), 64'(tlast));
                check_value("tid", exp_tid, tid);
                check_value("tdest", exp_tdest, tdest);
                check_value("tuser", exp_tuser, tuser);
                if (word_idx == exp_words - 1) begin
                    word_idx  <= 0;
                    pkts_seen <= pkts_seen + 1;
                end else begin
                    word_idx <= word_idx + 1;
                end
            end
        end
    end

    // Cycle budget and bound checker state
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            fail_run($sformatf("timeout, run still busy after %0d cycles", cycle_cnt));
        end else if (uut.i_chk.any_err) begin
            fail_run("bound assertion reported a failure");
        end
    end

    initial begin
        logic [31:0] rd_val;
        int          total;
        int          played;
        lfsr_state   = 32'd82023;
        rst_n        = 1'b0;
        wr_en        = 1'b0;
        wr_addr      = 3'd0;
        wr_data      = 32'd0;
        rd_en        = 1'b0;
        rd_addr      = 3'd0;
        tready       = 1'b1;
        pkts_started = 0;
        played       = 0;
        total        = 0;
        // len, tid, tdest, tuser, en, random tready
        tests[0] = '{16'd1,   8'h01, 8'h10, 16'h0a01, 1'b1, 1'b1};
        tests[1] = '{16'd8,   8'h02, 8'h20, 16'h0b02, 1'b1, 1'b1};
        tests[2] = '{16'd13,  8'h03, 8'h30, 16'h0c03, 1'b1, 1'b0};
        tests[3] = '{16'd13,  8'h04, 8'h40, 16'h0d04, 1'b1, 1'b1};
        tests[4] = '{16'd0,   8'h05, 8'h50, 16'h0e05, 1'b1, 1'b1};
        tests[5] = '{16'd16,  8'h06, 8'h60, 16'h0f06, 1'b0, 1'b1};
        tests[6] = '{16'd64,  8'h07, 8'h70, 16'h1007, 1'b1, 1'b1};
        tests[7] = '{16'd512, 8'h08, 8'h80, 16'h1108, 1'b1, 1'b1};
        // Words plus register writes, four times over
        for (int i = 0; i < NUM_TESTS; i++) begin
            total += 3 * word_count(tests[i].len);
            total += 5;
        end
        cycle_limit = 4 * total;

        // Four rising edges in reset, release on a falling edge
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value("tvalid", 0, 64'(tvalid));
        check_value("en", 0, 64'(en));
        read_reg(packet_playback_pkg::REG_STATUS, rd_val);
        check_value("status", 0, rd_val);

        for (int i = 0; i < NUM_TESTS; i++) begin
            exp_words = word_count(tests[i].len);
            write_reg(packet_playback_pkg::REG_MEM_ADDR, 32'd0);
            for (int w = 0; w < exp_words; w++) begin
                model[w] = random_word();
                write_reg(packet_playback_pkg::REG_MEM_LO, model[w][31:0]);
                write_reg(packet_playback_pkg::REG_MEM_HI, model[w][63:32]);
            end
            write_reg(packet_playback_pkg::REG_LEN, {16'd0, tests[i].len});
            write_reg(packet_playback_pkg::REG_META,
                      {tests[i].tuser, tests[i].tdest, tests[i].tid});
            exp_keep  = keep_mask(tests[i].len);
            exp_tid   = tests[i].tid;
            exp_tdest = tests[i].tdest;
            exp_tuser = tests[i].tuser;
            tready    = 1'b1;
            if (tests[i].enable) pkts_started = pkts_started + 1;
            write_reg(packet_playback_pkg::REG_CTRL, {30'd0, 1'b1, tests[i].enable});
            check_value("en", 64'(tests[i].enable), 64'(en));
            if (tests[i].enable) begin
                // Restart while busy, ignored
                @(negedge clk);
                write_reg(packet_playback_pkg::REG_CTRL, 32'd3);
                while (pkts_seen < pkts_started) begin
                    tready = tests[i].rand_rdy ? lfsr_bit() : 1'b1;
                    @(negedge clk);
                end
                played = played + 1;
                tready = 1'b1;
                // Count lands the cycle after pkt_done
                @(negedge clk);
            end else begin
                repeat (16) begin
                    @(negedge clk);
                    check_value("tvalid", 0, 64'(tvalid));
                end
            end
            read_reg(packet_playback_pkg::REG_STATUS, rd_val);
            check_value("status", {16'(played), 16'd0}, rd_val);
            read_reg(packet_playback_pkg::REG_CTRL, rd_val);
            check_value("ctrl", {31'd0, tests[i].enable}, rd_val);
        end

        if (uut.i_chk.any_err) begin
            fail_run("bound assertion reported a failure");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule : axi4s_packet_playback_tb

// File: sim/axi4s_packet_playback_chk.sv
// Bound assertions for the packet playback top level
// AXI-Stream hold rule, credit bound, busy and pkt_done pairing
module axi4s_packet_playback_chk #(
    parameter int DATA_BYTE_WID = 8
) (
    input logic                                      clk,
    input logic                                      rst_n,
    input logic                                      tvalid,
    input logic                                      tready,
    input logic [DATA_BYTE_WID*8-1:0]                tdata,
    input logic [DATA_BYTE_WID-1:0]                  tkeep,
    input logic                                      tlast,
    input logic [packet_playback_pkg::TID_WID-1:0]   tid,
    input logic [packet_playback_pkg::TDEST_WID-1:0] tdest,
    input logic [packet_playback_pkg::TUSER_WID-1:0] tuser,
    input logic [1:0]                                credit,
    input logic                                      busy,
    input logic                                      pkt_done
);
    // Sticky flags, one per assertion
    logic stall_err  = 1'b0;
    logic credit_err = 1'b0;
    logic busy_err   = 1'b0;
    logic any_err;

    assign any_err = stall_err | credit_err | busy_err;

    // Stalled word holds every field
    assert property (@(posedge clk) disable iff (!rst_n)
        tvalid && !tready |=> tvalid && $stable(tdata) && $stable(tkeep) &&
            $stable(tlast) && $stable(tid) && $stable(tdest) && $stable(tuser))
    else begin
        stall_err = 1'b1;
        $error("AXI-Stream word changed or dropped while stalled");
    end

    // Two FIFO slots at most
    assert property (@(posedge clk) disable iff (!rst_n) credit <= 2'd2)
    else begin
        credit_err = 1'b1;
        $error("controller credit above two");
    end

    // Busy ends only with the done pulse
    assert property (@(posedge clk) disable iff (!rst_n) $fell(busy) |-> pkt_done)
    else begin
        busy_err = 1'b1;
        $error("busy fell without pkt_done");
    end

endmodule : axi4s_packet_playback_chk

bind axi4s_packet_playback axi4s_packet_playback_chk #(
    .DATA_BYTE_WID ( DATA_BYTE_WID )
) i_chk (
    .clk, .rst_n, .tvalid, .tready, .tdata, .tkeep, .tlast, .tid, .tdest, .tuser,
    .credit ( i_packet_playback_ctrl.credit ),
    .busy, .pkt_done
);

// File: hdl/axi4s_packet_playback.sv
// Packet playback top level
// Register block, payload memory, controller and AXI-Stream adapter
module axi4s_packet_playback #(
    parameter int DATA_BYTE_WID    = 8,
    parameter int PACKET_MEM_DEPTH = 64,
    parameter bit IGNORE_TREADY    = 0
) (
    input  logic                                         clk,
    input  logic                                         rst_n,
    // Register access
    input  logic                                         wr_en,
    input  logic [2:0]                                   wr_addr,
    input  logic [packet_playback_pkg::REG_DATA_WID-1:0] wr_data,
    input  logic                                         rd_en,
    input  logic [2:0]                                   rd_addr,
    output logic [packet_playback_pkg::REG_DATA_WID-1:0] rd_data,
    output logic                                         en,
    // AXI-Stream transmit
    output logic                                         tvalid,
    input  logic                                         tready,
    output logic [DATA_BYTE_WID*8-1:0]                   tdata,
    output logic [DATA_BYTE_WID-1:0]                     tkeep,
    output logic                                         tlast,
    output logic [packet_playback_pkg::TID_WID-1:0]      tid,
    output logic [packet_playback_pkg::TDEST_WID-1:0]    tdest,
    output logic [packet_playback_pkg::TUSER_WID-1:0]    tuser
);
    localparam int ADDR_WID = $clog2(PACKET_MEM_DEPTH);

    // Register block to controller
    logic                                      start;
    logic                                      busy;
    logic                                      pkt_done;
    logic [packet_playback_pkg::LEN_WID-1:0]   len;
    logic [packet_playback_pkg::TID_WID-1:0]   cfg_tid;
    logic [packet_playback_pkg::TDEST_WID-1:0] cfg_tdest;
    logic [packet_playback_pkg::TUSER_WID-1:0] cfg_tuser;
    // Memory ports
    logic                                      mem_wr_en;
    logic [ADDR_WID-1:0]                       mem_wr_addr;
    logic [DATA_BYTE_WID*8-1:0]                mem_wr_data;
    logic                                      mem_rd_en;
    logic [ADDR_WID-1:0]                       mem_rd_addr;
    logic [DATA_BYTE_WID*8-1:0]                mem_rd_data;
    // Controller to adapter
    logic                                      word_push;
    logic [DATA_BYTE_WID*8-1:0]                word_data;
    logic [DATA_BYTE_WID-1:0]                  word_keep;
    logic                                      word_last;
    logic                                      word_taken;

    packet_playback_regs #(
        .DATA_BYTE_WID    ( DATA_BYTE_WID ),
        .PACKET_MEM_DEPTH ( PACKET_MEM_DEPTH )
    ) i_packet_playback_regs (
        .clk, .rst_n, .wr_en, .wr_addr, .wr_data, .rd_en, .rd_addr, .rd_data,
        .busy, .pkt_done, .en, .start, .len,
        .tid ( cfg_tid ), .tdest ( cfg_tdest ), .tuser ( cfg_tuser ),
        .mem_wr_en, .mem_wr_addr, .mem_wr_data
    );

    packet_mem #(
        .DATA_BYTE_WID    ( DATA_BYTE_WID ),
        .PACKET_MEM_DEPTH ( PACKET_MEM_DEPTH )
    ) i_packet_mem (
        .clk,
        .wr_en ( mem_wr_en ), .wr_addr ( mem_wr_addr ), .wr_data ( mem_wr_data ),
        .rd_en ( mem_rd_en ), .rd_addr ( mem_rd_addr ), .rd_data ( mem_rd_data )
    );

    packet_playback_ctrl #(
        .DATA_BYTE_WID    ( DATA_BYTE_WID ),
        .PACKET_MEM_DEPTH ( PACKET_MEM_DEPTH )
    ) i_packet_playback_ctrl (
        .clk, .rst_n, .start, .len, .busy, .pkt_done,
        .mem_rd_en, .mem_rd_addr, .mem_rd_data,
        .word_push, .word_data, .word_keep, .word_last, .word_taken
    );

    axi4s_from_packet_adapter #(
        .DATA_BYTE_WID ( DATA_BYTE_WID ),
        .IGNORE_TREADY ( IGNORE_TREADY )
    ) i_axi4s_from_packet_adapter (
        .clk, .rst_n, .word_push, .word_data, .word_keep, .word_last, .word_taken,
        .tid_in ( cfg_tid ), .tdest_in ( cfg_tdest ), .tuser_in ( cfg_tuser ),
        .tvalid, .tready, .tdata, .tkeep, .tlast, .tid, .tdest, .tuser
    );

endmodule : axi4s_packet_playback

// File: hdl/axi4s_from_packet_adapter.sv
// AXI-Stream transmit adapter
// Two-entry word FIFO, metadata held per packet
module axi4s_from_packet_adapter #(
    parameter int DATA_BYTE_WID = 8,
    parameter bit IGNORE_TREADY = 0
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    // Words from the controller
    input  logic                                      word_push,
    input  logic [DATA_BYTE_WID*8-1:0]                word_data,
    input  logic [DATA_BYTE_WID-1:0]                  word_keep,
    input  logic                                      word_last,
    output logic                                      word_taken,
    // Metadata from the register block
    input  logic [packet_playback_pkg::TID_WID-1:0]   tid_in,
    input  logic [packet_playback_pkg::TDEST_WID-1:0] tdest_in,
    input  logic [packet_playback_pkg::TUSER_WID-1:0] tuser_in,
    // AXI-Stream transmit
    output logic                                      tvalid,
    input  logic                                      tready,
    output logic [DATA_BYTE_WID*8-1:0]                tdata,
    output logic [DATA_BYTE_WID-1:0]                  tkeep,
    output logic                                      tlast,
    output logic [packet_playback_pkg::TID_WID-1:0]   tid,
    output logic [packet_playback_pkg::TDEST_WID-1:0] tdest,
    output logic [packet_playback_pkg::TUSER_WID-1:0] tuser
);
    // FIFO storage
    logic [DATA_BYTE_WID*8-1:0] data_q [2];
    logic [DATA_BYTE_WID-1:0]   keep_q [2];
    logic [1:0]                 last_q;
    logic                       wr_ptr;
    logic                       rd_ptr;
    logic [1:0]                 count;
    logic                       pop;
    logic                       in_pkt;

    // tready forced high when ignored
    assign pop        = tvalid && (IGNORE_TREADY || tready);
    assign word_taken = pop;

    // Head of the FIFO drives the stream
    assign tvalid = (count != 2'd0);
    assign tdata  = data_q[rd_ptr];
    assign tkeep  = keep_q[rd_ptr];
    assign tlast  = last_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
            in_pkt <= 1'b0;
        end else begin
            if (word_push) wr_ptr <= ~wr_ptr;
            if (pop) rd_ptr <= ~rd_ptr;
            count <= count + {1'b0, word_push} - {1'b0, pop};
            // Open on first push, close when tlast leaves
            if (word_push) begin
                in_pkt <= 1'b1;
            end else if (pop && tlast) begin
                in_pkt <= 1'b0;
            end
        end
    end

    // Payload and metadata
    always_ff @(posedge clk) begin
        if (word_push) begin
            data_q[wr_ptr] <= word_data;
            keep_q[wr_ptr] <= word_keep;
            last_q[wr_ptr] <= word_last;
        end
        // Sampled between packets only
        if (!in_pkt) begin
            tid   <= tid_in;
            tdest <= tdest_in;
            tuser <= tuser_in;
        end
    end

endmodule : axi4s_from_packet_adapter

// File: hdl/packet_playback_ctrl.sv
// Playback controller
// Read sequencing against output credit, tkeep and tlast generation
module packet_playback_ctrl #(
    parameter int DATA_BYTE_WID    = 8,
    parameter int PACKET_MEM_DEPTH = 64
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    // From the register block
    input  logic                                    start,
    input  logic [packet_playback_pkg::LEN_WID-1:0] len,
    output logic                                    busy,
    output logic                                    pkt_done,
    // Memory read port
    output logic                                    mem_rd_en,
    output logic [$clog2(PACKET_MEM_DEPTH)-1:0]     mem_rd_addr,
    input  logic [DATA_BYTE_WID*8-1:0]              mem_rd_data,
    // Words to the output adapter
    output logic                                    word_push,
    output logic [DATA_BYTE_WID*8-1:0]              word_data,
    output logic [DATA_BYTE_WID-1:0]                word_keep,
    output logic                                    word_last,
    input  logic                                    word_taken
);
    localparam int ADDR_WID     = $clog2(PACKET_MEM_DEPTH);
    localparam int BYTE_IDX_WID = $clog2(DATA_BYTE_WID);
    localparam int LEN_WID      = packet_playback_pkg::LEN_WID;

    packet_playback_pkg::play_state_e state;

    // Index of the last byte, zero length treated as one byte
    logic [LEN_WID-1:0]      len_m1;
    // Latched at start
    logic [LEN_WID-1:0]      last_idx;
    logic [DATA_BYTE_WID-1:0] last_keep;
    // Next word to read
    logic [LEN_WID-1:0]      rd_idx;
    logic                    rd_last;
    // Free slots in the adapter buffer
    logic [1:0]              credit;

    assign len_m1 = (len == '0) ? '0 : len - 1'b1;

    // Read whenever a buffer slot is free
    assign mem_rd_en   = (state == packet_playback_pkg::ST_READ) && (credit != 2'd0);
    assign mem_rd_addr = rd_idx[ADDR_WID-1:0];
    assign rd_last     = (rd_idx == last_idx);

    assign busy = (state != packet_playback_pkg::ST_IDLE);

    // Memory data lines up with the push
    assign word_data = mem_rd_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= packet_playback_pkg::ST_IDLE;
            credit    <= 2'd2;
            rd_idx    <= '0;
            pkt_done  <= 1'b0;
            word_push <= 1'b0;
        end else begin
            pkt_done  <= 1'b0;
            word_push <= mem_rd_en;
            // One spent per read, one back per accepted word
            credit <= credit - {1'b0, mem_rd_en} + {1'b0, word_taken};
            case (state)
                packet_playback_pkg::ST_IDLE: begin
                    rd_idx <= '0;
                    if (start) begin
                        state <= packet_playback_pkg::ST_READ;
                    end
                end
                packet_playback_pkg::ST_READ: begin
                    if (mem_rd_en) begin
                        rd_idx <= rd_idx + 1'b1;
                        if (rd_last) begin
                            state <= packet_playback_pkg::ST_DRAIN;
                        end
                    end
                end
                packet_playback_pkg::ST_DRAIN: begin
                    // Credit back to two means every word is out
                    if (word_taken && credit == 2'd1) begin
                        state    <= packet_playback_pkg::ST_IDLE;
                        pkt_done <= 1'b1;
                    end
                end
                default: state <= packet_playback_pkg::ST_IDLE;
            endcase
        end
    end

    // Packet geometry and per-word flags
    always_ff @(posedge clk) begin
        if (start && state == packet_playback_pkg::ST_IDLE) begin
            last_idx  <= len_m1 >> BYTE_IDX_WID;
            // Bytes 0 up to the last byte index
            last_keep <= {DATA_BYTE_WID{1'b1}} >>
                         (DATA_BYTE_WID - 1 - int'(len_m1[BYTE_IDX_WID-1:0]));
        end
        if (mem_rd_en) begin
            word_last <= rd_last;
            word_keep <= rd_last ? last_keep : {DATA_BYTE_WID{1'b1}};
        end
    end

endmodule : packet_playback_ctrl

// File: hdl/packet_mem.sv
// Payload memory for packet playback
// Simple dual-port array, one-cycle registered read
module packet_mem #(
    parameter int DATA_BYTE_WID    = 8,
    parameter int PACKET_MEM_DEPTH = 64
) (
    input  logic                                clk,
    // Write port, from the register block
    input  logic                                wr_en,
    input  logic [$clog2(PACKET_MEM_DEPTH)-1:0] wr_addr,
    input  logic [DATA_BYTE_WID*8-1:0]          wr_data,
    // Read port, from the controller
    input  logic                                rd_en,
    input  logic [$clog2(PACKET_MEM_DEPTH)-1:0] rd_addr,
    output logic [DATA_BYTE_WID*8-1:0]          rd_data
);
    localparam int DATA_WID = DATA_BYTE_WID * 8;

    // Storage, contents undefined until written
    logic [DATA_WID-1:0] mem [PACKET_MEM_DEPTH];

    // Write side
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read side, data one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule : packet_mem

// File: hdl/packet_playback_regs.sv
// Register block for packet playback
// Write decode, config registers, memory write port, status readback
module packet_playback_regs #(
    parameter int DATA_BYTE_WID    = 8,
    parameter int PACKET_MEM_DEPTH = 64
) (
    input  logic                                          clk,
    input  logic                                          rst_n,
    // Register write strobe
    input  logic                                          wr_en,
    input  logic [2:0]                                    wr_addr,
    input  logic [packet_playback_pkg::REG_DATA_WID-1:0]  wr_data,
    // Register read strobe
    input  logic                                          rd_en,
    input  logic [2:0]                                    rd_addr,
    output logic [packet_playback_pkg::REG_DATA_WID-1:0]  rd_data,
    // Controller status
    input  logic                                          busy,
    input  logic                                          pkt_done,
    // Controller config
    output logic                                          en,
    output logic                                          start,
    output logic [packet_playback_pkg::LEN_WID-1:0]       len,
    output logic [packet_playback_pkg::TID_WID-1:0]       tid,
    output logic [packet_playback_pkg::TDEST_WID-1:0]     tdest,
    output logic [packet_playback_pkg::TUSER_WID-1:0]     tuser,
    // Payload memory write port
    output logic                                          mem_wr_en,
    output logic [$clog2(PACKET_MEM_DEPTH)-1:0]           mem_wr_addr,
    output logic [DATA_BYTE_WID*8-1:0]                    mem_wr_data
);
    localparam int ADDR_WID = $clog2(PACKET_MEM_DEPTH);

    // Memory word pointer
    logic [ADDR_WID-1:0] mem_ptr;
    // Low half waiting for its high half
    logic [packet_playback_pkg::REG_DATA_WID-1:0] mem_lo;
    // Finished packet count
    logic [15:0] pkt_cnt;

    // Control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            en        <= 1'b0;
            start     <= 1'b0;
            len       <= '0;
            tid       <= '0;
            tdest     <= '0;
            tuser     <= '0;
            mem_ptr   <= '0;
            mem_wr_en <= 1'b0;
            pkt_cnt   <= '0;
        end else begin
            start     <= 1'b0;
            mem_wr_en <= 1'b0;
            if (pkt_done) begin
                pkt_cnt <= pkt_cnt + 1'b1;
            end
            if (wr_en) begin
                case (wr_addr)
                    packet_playback_pkg::REG_CTRL: begin
                        en <= wr_data[0];
                        // Start only if enabled and idle
                        start <= wr_data[0] & wr_data[1] & ~busy;
                    end
                    packet_playback_pkg::REG_LEN: len <= wr_data[15:0];
                    packet_playback_pkg::REG_META: begin
                        tid   <= wr_data[7:0];
                        tdest <= wr_data[15:8];
                        tuser <= wr_data[31:16];
                    end
                    packet_playback_pkg::REG_MEM_ADDR: mem_ptr <= wr_data[ADDR_WID-1:0];
                    packet_playback_pkg::REG_MEM_HI: begin
                        mem_wr_en <= 1'b1;
                        // Post-increment for the next word
                        mem_ptr   <= mem_ptr + 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // Payload path, no reset
    always_ff @(posedge clk) begin
        if (wr_en && wr_addr == packet_playback_pkg::REG_MEM_LO) begin
            mem_lo <= wr_data;
        end
        if (wr_en && wr_addr == packet_playback_pkg::REG_MEM_HI) begin
            mem_wr_addr <= mem_ptr;
            mem_wr_data <= {wr_data, mem_lo};
        end
        // Read data held until the next read
        if (rd_en) begin
            case (rd_addr)
                packet_playback_pkg::REG_CTRL:     rd_data <= {31'd0, en};
                packet_playback_pkg::REG_STATUS:   rd_data <= {pkt_cnt, 15'd0, busy};
                packet_playback_pkg::REG_LEN:      rd_data <= {16'd0, len};
                packet_playback_pkg::REG_META:     rd_data <= {tuser, tdest, tid};
                packet_playback_pkg::REG_MEM_ADDR: rd_data <= 32'(mem_ptr);
                packet_playback_pkg::REG_MEM_LO:   rd_data <= mem_lo;
                default:                           rd_data <= '0;
            endcase
        end
    end

endmodule : packet_playback_regs

// File: hdl/packet_playback_pkg.sv
// Shared definitions for the packet playback block
// Register word map, controller states, field widths
package packet_playback_pkg;

    // Register data path
    localparam int REG_DATA_WID = 32;

    // Metadata field widths
    localparam int TID_WID   = 8;
    localparam int TDEST_WID = 8;
    localparam int TUSER_WID = 16;

    // Byte length field
    localparam int LEN_WID = 16;

    // Word addresses of the register map
    typedef enum logic [2:0] {
        // Bit 0 en level, bit 1 start strobe
        REG_CTRL     = 3'd0,
        // Read-only, busy in bit 0, sent count in 31:16
        REG_STATUS   = 3'd1,
        REG_LEN      = 3'd2,
        // tid 7:0, tdest 15:8, tuser 31:16
        REG_META     = 3'd3,
        REG_MEM_ADDR = 3'd4,
        REG_MEM_LO   = 3'd5,
        // Commits the 64-bit word
        REG_MEM_HI   = 3'd6
    } reg_addr_e;

    // Playback controller states
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_READ  = 2'd1,
        ST_DRAIN = 2'd2
    } play_state_e;

endpackage : packet_playback_pkg
